/* Makefile */
SRC := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_frame_buffer_ctrl
	./obj_dir/Vtb_frame_buffer_ctrl

obj_dir/Vtb_frame_buffer_ctrl: flist.f $(SRC)
	verilator --binary --timing --assert --top-module tb_frame_buffer_ctrl -f flist.f

clean:
	rm -rf obj_dir

/* bench/tb_frame_buffer_ctrl.sv */
`timescale 1ns/1ns
`include "vfb_macros.svh"

module tb_frame_buffer_ctrl;

    localparam int FP     = `VFB_FRAME_PIXELS;
    localparam int STRIDE = `VFB_FRAME_PIXELS + `VFB_ADDR_GAP;
    localparam int QN     = 1024;

    logic clk;
    logic rst_n;
    logic init_done_i;
    logic load_empty_i;
    logic store_full_i;
    logic rd_data_valid_i;
    logic cmd_o;
    logic cmd_en_o;
    logic load_rd_en_o;
    logic store_wr_en_o;
    vfb_pkg::mem_data_t rd_data_i;
    vfb_pkg::mem_data_t wr_data_o;
    vfb_pkg::mem_addr_t addr_o;
    vfb_pkg::pixel_t    load_data_i;
    vfb_pkg::pixel_t    store_data_o;

    logic [31:0]        rng;
    vfb_pkg::pixel_t    load_q [QN];
    int                 pop_ptr;
    int                 init_cnt;
    int                 wr_cnt;
    int                 rd_cnt;
    int                 push_cnt;
    int                 head;
    int                 tail;
    int                 up_start [3];
    logic               written [3];
    vfb_pkg::mem_addr_t cur_wr_base;
    vfb_pkg::mem_addr_t cur_rd_base;
    vfb_pkg::mem_addr_t rd_fifo [8];
    vfb_pkg::mem_addr_t front;
    vfb_pkg::pixel_t    exp_pixel;
    vfb_pkg::pixel_t    exp_push_mem;
    vfb_pkg::pixel_t    exp_push_pix;
    logic               wr_cmd;
    logic               rd_cmd;
    int                 wr_off;
    int                 rd_off;
    int                 front_buf;

    frame_buffer_ctrl i_dut (.*);

    tb_psram_model i_mem (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_en_i        (cmd_en_o),
        .cmd_i           (cmd_o),
        .addr_i          (addr_o),
        .wr_data_i       (wr_data_o),
        .rd_data_o       (rd_data_i),
        .rd_data_valid_o (rd_data_valid_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    assign wr_cmd       = cmd_en_o && cmd_o;
    assign rd_cmd       = cmd_en_o && !cmd_o;
    assign wr_off       = wr_cnt % FP;
    assign rd_off       = rd_cnt % FP;
    assign exp_pixel    = load_q[pop_ptr % QN];
    assign front        = rd_fifo[head % 8];
    assign front_buf    = int'(front) / STRIDE;
    assign exp_push_mem = i_mem.mem[front[6:0]][16:0];
    assign exp_push_pix = load_q[(up_start[front_buf] + int'(front) % STRIDE) % QN];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reference bookkeeping, updated after each edge is checked
    always @(posedge clk) begin
        if (!rst_n) begin
            pop_ptr  <= 0;
            init_cnt <= 0;
            wr_cnt   <= 0;
            rd_cnt   <= 0;
            push_cnt <= 0;
            head     <= 0;
            tail     <= 0;
            for (int b = 0; b < 3; b++) begin
                written[b]  <= 1'b0;
                up_start[b] <= 0;
            end
        end else begin
            if (init_done_i && init_cnt < `VFB_STARTUP_DELAY) begin
                init_cnt <= init_cnt + 1;
            end
            if (load_rd_en_o) begin
                pop_ptr <= pop_ptr + 1;
            end
            if (wr_cmd) begin
                wr_cnt <= wr_cnt + 1;
                if (wr_off == 0) begin
                    cur_wr_base                      <= addr_o;
                    up_start[int'(addr_o) / STRIDE] <= pop_ptr;
                end
                if (wr_off == FP - 1) begin
                    written[int'(cur_wr_base) / STRIDE] <= 1'b1;
                end
            end
            if (rd_cmd) begin
                rd_cnt           <= rd_cnt + 1;
                rd_fifo[tail % 8] <= addr_o;
                tail             <= tail + 1;
                if (rd_off == 0) begin
                    cur_rd_base <= addr_o;
                end
            end
            if (store_wr_en_o) begin
                head     <= head + 1;
                push_cnt <= push_cnt + 1;
            end
        end
    end

    // queue stimulus on the falling edge
    always @(negedge clk) begin
        rng = xorshift32(rng);
        load_empty_i <= (rng[1:0] == 2'd0);
        store_full_i <= (rng[4:2] < 3'd2);
        load_data_i  <= load_q[pop_ptr % QN];
        if (rst_n) begin
            init_done_i <= rng[8] || (init_cnt >= 12);
        end
    end

    a_startup: assert property (@(posedge clk) disable iff (!rst_n)
        (init_cnt < `VFB_STARTUP_DELAY) |-> !(cmd_en_o || load_rd_en_o || store_wr_en_o))
        else stop_on_error("memory or queue activity before the start-up delay ran out");

    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        load_rd_en_o |-> !load_empty_i)
        else stop_on_error("load queue popped while empty");

    a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cmd |-> (load_rd_en_o && wr_data_o == 32'(exp_pixel)))
        else stop_on_error($sformatf("Error: wr_data_o = %h, expected %h", wr_data_o, exp_pixel));

    a_wr_base: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_cmd && wr_off == 0) |-> (int'(addr_o) % STRIDE == 0 &&
            int'(addr_o) <= 2 * STRIDE && (wr_cnt != 0 || int'(addr_o) == 2 * STRIDE)))
        else stop_on_error($sformatf("Error: addr_o = %h, not a valid write base", addr_o));

    a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_cmd && wr_off != 0) |-> addr_o == cur_wr_base + 21'(wr_off))
        else stop_on_error($sformatf("Error: addr_o = %h, expected %h",
                                     addr_o, cur_wr_base + 21'(wr_off)));

    a_rd_base: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_cmd && rd_off == 0) |-> (int'(addr_o) % STRIDE == 0 &&
            int'(addr_o) <= 2 * STRIDE && (rd_cnt != 0 || int'(addr_o) == STRIDE)))
        else stop_on_error($sformatf("Error: addr_o = %h, not a valid read base", addr_o));

    a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_cmd && rd_off != 0) |-> addr_o == cur_rd_base + 21'(rd_off))
        else stop_on_error($sformatf("Error: addr_o = %h, expected %h",
                                     addr_o, cur_rd_base + 21'(rd_off)));

    // any tracked entry is a read in flight or a held word
    a_rd_single: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd |-> (tail == head))
        else stop_on_error("read issued while a read or a held word is pending");

    a_addr_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_en_o |-> addr_o == '0)
        else stop_on_error($sformatf("Error: addr_o = %h, expected %h", addr_o, 21'h0));

    a_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        store_wr_en_o |-> !store_full_i)
        else stop_on_error("store queue written while full");

    a_push_read: assert property (@(posedge clk) disable iff (!rst_n)
        store_wr_en_o |-> (tail != head))
        else stop_on_error("store queue written with no read behind it");

    a_push_mem: assert property (@(posedge clk) disable iff (!rst_n)
        store_wr_en_o |-> store_data_o == exp_push_mem)
        else stop_on_error($sformatf("Error: store_data_o = %h, expected %h",
                                     store_data_o, exp_push_mem));

    a_push_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (store_wr_en_o && written[front_buf]) |-> store_data_o == exp_push_pix)
        else stop_on_error($sformatf("Error: store_data_o = %h, expected %h",
                                     store_data_o, exp_push_pix));

    initial begin
        int t;
        rng          = 32'd42;
        rst_n        = 1'b0;
        init_done_i  = 1'b0;
        load_empty_i = 1'b1;
        store_full_i = 1'b0;
        load_data_i  = '0;
        for (int i = 0; i < QN; i++) begin
            rng       = xorshift32(rng);
            load_q[i] = rng[16:0];
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // three uploads and two downloads
        for (t = 0; t < 20000 && !(wr_cnt >= 3 * FP && push_cnt >= 2 * FP); t++) begin
            @(posedge clk);
        end
        if (wr_cnt >= 3 * FP && push_cnt >= 2 * FP) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("timed out waiting for three uploads and two downloads");
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

/* bench/tb_psram_model.sv */
`timescale 1ns/1ns

module tb_psram_model (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_en_i,
    input  logic               cmd_i,
    input  vfb_pkg::mem_addr_t addr_i,
    input  vfb_pkg::mem_data_t wr_data_i,
    output vfb_pkg::mem_data_t rd_data_o,
    output logic               rd_data_valid_o
);

    localparam int WORDS = 128;

    vfb_pkg::mem_data_t mem [0:WORDS-1];
    vfb_pkg::mem_addr_t rd_addr;
    logic [31:0]        rng = 32'd42;
    logic [31:0]        wait_cnt;
    logic               busy;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // power-up contents, a hash of the full address
    function automatic vfb_pkg::mem_data_t fill_word(input int a);
        return 32'hA5C3_0000 ^ (32'(a) * 32'h9E37_79B1);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < WORDS; a++) begin
                mem[a] <= fill_word(a);
            end
            busy            <= 1'b0;
            wait_cnt        <= '0;
            rd_addr         <= '0;
            rd_data_o       <= '0;
            rd_data_valid_o <= 1'b0;
        end else begin
            rd_data_valid_o <= 1'b0;
            if (busy) begin
                if (wait_cnt == 32'd1) begin
                    rd_data_valid_o <= 1'b1;
                    rd_data_o       <= mem[rd_addr[6:0]];
                    busy            <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 32'd1;
                end
            end
            if (cmd_en_i && cmd_i) begin
                mem[addr_i[6:0]] <= wr_data_i;
            end
            if (cmd_en_i && !cmd_i) begin
                // latency of 1 to 6 cycles
                rng      <= xorshift32(rng);
                wait_cnt <= 32'd1 + (xorshift32(rng) % 32'd6);
                rd_addr  <= addr_i;
                busy     <= 1'b1;
            end
        end
    end

endmodule

/* flist.f */
+incdir+source
source/vfb_pkg.sv
source/startup_timer.sv
source/buffer_sequencer.sv
source/buffer_table.sv
source/frame_writer.sv
source/frame_reader.sv
source/mem_cmd_arbiter.sv
source/frame_buffer_ctrl.sv
bench/tb_psram_model.sv
bench/tb_frame_buffer_ctrl.sv

/* source/buffer_sequencer.sv */
`timescale 1ns/1ns

module buffer_sequencer #(
    parameter vfb_pkg::seq_role_e ROLE = vfb_pkg::ROLE_PRODUCER
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready_i,
    output vfb_pkg::table_req_t req_o,
    input  vfb_pkg::table_rsp_t rsp_i,
    output logic                start_o,
    output vfb_pkg::mem_addr_t  base_o,
    input  logic                done_i
);

    localparam string ROLE_NAME = (ROLE == vfb_pkg::ROLE_PRODUCER) ? "producer" : "consumer";

    typedef enum logic [2:0] {
        S_WAIT,
        S_ACQUIRE,
        S_START,
        S_BUSY,
        S_RELEASE
    } state_e;

    state_e             state_q;
    state_e             state_d;
    vfb_pkg::mem_addr_t base_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_WAIT:    if (ready_i) state_d = S_ACQUIRE;
            S_ACQUIRE: if (rsp_i.grant) state_d = S_START;
            S_START:   state_d = S_BUSY;
            S_BUSY:    if (done_i) state_d = S_RELEASE;
            // straight back for the next frame
            S_RELEASE: if (rsp_i.grant) state_d = S_ACQUIRE;
            default:   state_d = S_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_WAIT;
        end else begin
            state_q <= state_d;
        end
    end

    // base of the buffer just granted
    always_ff @(posedge clk) begin
        if (state_q == S_ACQUIRE && rsp_i.grant) begin
            base_q <= rsp_i.base;
        end
    end

    assign req_o.acq = (state_q == S_ACQUIRE);
    assign req_o.rel = (state_q == S_RELEASE);
    assign start_o   = (state_q == S_START);
    assign base_o    = base_q;

    // the table only answers a request that was pending
    a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_i.grant |-> $past(req_o.acq || req_o.rel))
        else $error("%s sequencer got a grant it did not request", ROLE_NAME);

endmodule

/* source/buffer_table.sv */
`timescale 1ns/1ns
`include "vfb_macros.svh"

module buffer_table (
    input  logic                clk,
    input  logic                rst_n,
    input  vfb_pkg::table_req_t prod_req_i,
    input  vfb_pkg::table_req_t cons_req_i,
    output vfb_pkg::table_rsp_t prod_rsp_o,
    output vfb_pkg::table_rsp_t cons_rsp_o
);

    localparam int NB     = `VFB_NUM_BUFFERS;
    localparam int STRIDE = `VFB_FRAME_PIXELS + `VFB_ADDR_GAP;

    vfb_pkg::buf_state_e buf_st [NB];
    vfb_pkg::buf_idx_t   prod_idx;
    vfb_pkg::buf_idx_t   cons_idx;
    vfb_pkg::table_rsp_t prod_rsp_q;
    vfb_pkg::table_rsp_t cons_rsp_q;
    logic                prio_cons;
    logic                prod_elig;
    logic                cons_elig;
    logic                serve_prod;
    logic                serve_cons;
    logic [2:0]          prod_pick;
    logic [2:0]          cons_pick;
    logic [NB-1:0]       wr_busy;
    logic [NB-1:0]       rd_busy;

    // {found, idx}: first matching preference, highest index within it
    function automatic logic [2:0] pick_buf(input vfb_pkg::buf_state_e st [NB],
                                            input vfb_pkg::buf_state_e p0,
                                            input vfb_pkg::buf_state_e p1,
                                            input vfb_pkg::buf_state_e p2);
        logic [2:0]          res;
        vfb_pkg::buf_state_e pref [3];
        res  = '0;
        pref = '{p0, p1, p2};
        for (int p = 2; p >= 0; p--) begin
            for (int i = 0; i < NB; i++) begin
                if (st[i] == pref[p]) begin
                    res = {1'b1, vfb_pkg::buf_idx_t'(i)};
                end
            end
        end
        return res;
    endfunction

    function automatic vfb_pkg::mem_addr_t base_of(input vfb_pkg::buf_idx_t idx);
        return vfb_pkg::mem_addr_t'(idx) * vfb_pkg::mem_addr_t'(STRIDE);
    endfunction

    always_comb begin
        // a side whose grant is out is not served again
        prod_elig  = (prod_req_i.acq || prod_req_i.rel) && !prod_rsp_q.grant;
        cons_elig  = (cons_req_i.acq || cons_req_i.rel) && !cons_rsp_q.grant;
        serve_prod = prod_elig && (!cons_elig || !prio_cons);
        serve_cons = cons_elig && !serve_prod;
        prod_pick  = pick_buf(buf_st, vfb_pkg::BUF_DISPLAYED, vfb_pkg::BUF_AVAILABLE,
                              vfb_pkg::BUF_UPDATED);
        cons_pick  = pick_buf(buf_st, vfb_pkg::BUF_UPDATED, vfb_pkg::BUF_AVAILABLE,
                              vfb_pkg::BUF_DISPLAYED);
        for (int i = 0; i < NB; i++) begin
            wr_busy[i] = (buf_st[i] == vfb_pkg::BUF_WRITE_BUSY);
            rd_busy[i] = (buf_st[i] == vfb_pkg::BUF_READ_BUSY);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NB; i++) begin
                buf_st[i] <= vfb_pkg::BUF_AVAILABLE;
            end
            prod_idx   <= '0;
            cons_idx   <= '0;
            prod_rsp_q <= '0;
            cons_rsp_q <= '0;
            prio_cons  <= 1'b0;
        end else begin
            prod_rsp_q.grant <= serve_prod;
            cons_rsp_q.grant <= serve_cons;
            if (serve_prod || serve_cons) begin
                prio_cons <= serve_prod;
            end
            if (serve_prod && prod_req_i.acq) begin
                buf_st[prod_pick[1:0]] <= vfb_pkg::BUF_WRITE_BUSY;
                prod_idx               <= prod_pick[1:0];
                prod_rsp_q.idx         <= prod_pick[1:0];
                prod_rsp_q.base        <= base_of(prod_pick[1:0]);
            end else if (serve_prod) begin
                buf_st[prod_idx] <= vfb_pkg::BUF_UPDATED;
                prod_rsp_q.idx   <= prod_idx;
                prod_rsp_q.base  <= base_of(prod_idx);
            end
            if (serve_cons && cons_req_i.acq) begin
                buf_st[cons_pick[1:0]] <= vfb_pkg::BUF_READ_BUSY;
                cons_idx               <= cons_pick[1:0];
                cons_rsp_q.idx         <= cons_pick[1:0];
                cons_rsp_q.base        <= base_of(cons_pick[1:0]);
            end else if (serve_cons) begin
                buf_st[cons_idx] <= vfb_pkg::BUF_DISPLAYED;
                cons_rsp_q.idx   <= cons_idx;
                cons_rsp_q.base  <= base_of(cons_idx);
            end
        end
    end

    assign prod_rsp_o = prod_rsp_q;
    assign cons_rsp_o = cons_rsp_q;

    // each side holds at most one buffer, so the two never share one
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wr_busy) && $onehot0(rd_busy))
        else $error("buffer table holds more than one busy buffer per side");

    a_candidate: assert property (@(posedge clk) disable iff (!rst_n)
        ((serve_prod && prod_req_i.acq) |-> prod_pick[2]) and
        ((serve_cons && cons_req_i.acq) |-> cons_pick[2]))
        else $error("no buffer available for an acquire");

endmodule

/* source/frame_buffer_ctrl.sv */
`timescale 1ns/1ns

module frame_buffer_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               init_done_i,
    // memory port
    input  vfb_pkg::mem_data_t rd_data_i,
    input  logic               rd_data_valid_i,
    output vfb_pkg::mem_addr_t addr_o,
    output logic               cmd_o,
    output logic               cmd_en_o,
    output vfb_pkg::mem_data_t wr_data_o,
    // load queue
    output logic               load_rd_en_o,
    input  logic               load_empty_i,
    input  vfb_pkg::pixel_t    load_data_i,
    // store queue
    output logic               store_wr_en_o,
    input  logic               store_full_i,
    output vfb_pkg::pixel_t    store_data_o
);

    logic                ready;
    vfb_pkg::table_req_t prod_req;
    vfb_pkg::table_req_t cons_req;
    vfb_pkg::table_rsp_t prod_rsp;
    vfb_pkg::table_rsp_t cons_rsp;
    logic                wr_start;
    logic                rd_start;
    logic                wr_done;
    logic                rd_done;
    vfb_pkg::mem_addr_t  wr_base;
    vfb_pkg::mem_addr_t  rd_base;
    vfb_pkg::mem_cmd_t   wr_cmd;
    vfb_pkg::mem_cmd_t   rd_cmd;
    logic                wr_valid;
    logic                rd_valid;
    logic                wr_grant;
    logic                rd_grant;

    startup_timer i_startup_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done_i (init_done_i),
        .ready_o     (ready)
    );

    buffer_sequencer #(.ROLE(vfb_pkg::ROLE_PRODUCER)) i_upload_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .ready_i (ready),
        .req_o   (prod_req),
        .rsp_i   (prod_rsp),
        .start_o (wr_start),
        .base_o  (wr_base),
        .done_i  (wr_done)
    );

    buffer_sequencer #(.ROLE(vfb_pkg::ROLE_CONSUMER)) i_download_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .ready_i (ready),
        .req_o   (cons_req),
        .rsp_i   (cons_rsp),
        .start_o (rd_start),
        .base_o  (rd_base),
        .done_i  (rd_done)
    );

    buffer_table i_buffer_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_req_i (prod_req),
        .cons_req_i (cons_req),
        .prod_rsp_o (prod_rsp),
        .cons_rsp_o (cons_rsp)
    );

    frame_writer i_frame_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (wr_start),
        .base_i       (wr_base),
        .load_empty_i (load_empty_i),
        .load_data_i  (load_data_i),
        .load_rd_en_o (load_rd_en_o),
        .cmd_o        (wr_cmd),
        .cmd_valid_o  (wr_valid),
        .cmd_grant_i  (wr_grant),
        .done_o       (wr_done)
    );

    frame_reader i_frame_reader (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (rd_start),
        .base_i          (rd_base),
        .cmd_o           (rd_cmd),
        .cmd_valid_o     (rd_valid),
        .cmd_grant_i     (rd_grant),
        .rd_data_i       (rd_data_i),
        .rd_data_valid_i (rd_data_valid_i),
        .store_full_i    (store_full_i),
        .store_wr_en_o   (store_wr_en_o),
        .store_data_o    (store_data_o),
        .done_o          (rd_done)
    );

    mem_cmd_arbiter i_mem_cmd_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_cmd_i   (wr_cmd),
        .rd_cmd_i   (rd_cmd),
        .wr_valid_i (wr_valid),
        .rd_valid_i (rd_valid),
        .wr_grant_o (wr_grant),
        .rd_grant_o (rd_grant),
        .addr_o     (addr_o),
        .cmd_o      (cmd_o),
        .cmd_en_o   (cmd_en_o),
        .wr_data_o  (wr_data_o)
    );

endmodule

/* source/frame_reader.sv */
`timescale 1ns/1ns
`include "vfb_macros.svh"

module frame_reader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  vfb_pkg::mem_addr_t base_i,
    output vfb_pkg::mem_cmd_t  cmd_o,
    output logic               cmd_valid_o,
    input  logic               cmd_grant_i,
    input  vfb_pkg::mem_data_t rd_data_i,
    input  logic               rd_data_valid_i,
    input  logic               store_full_i,
    output logic               store_wr_en_o,
    output vfb_pkg::pixel_t    store_data_o,
    output logic               done_o
);

    localparam int CNT_W = $clog2(`VFB_FRAME_PIXELS);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`VFB_FRAME_PIXELS - 1);

    logic             run_q;
    logic             issued_all_q;
    logic             pending_q;
    logic             hold_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    vfb_pkg::pixel_t  hold_data_q;
    logic             fire;
    logic             rd_ret;

    // at most one read in flight and none while a word is parked
    assign cmd_valid_o = run_q && !issued_all_q && !pending_q && !hold_q;
    assign fire        = cmd_valid_o && cmd_grant_i;
    assign rd_ret      = rd_data_valid_i && pending_q;

    assign store_wr_en_o = (hold_q || rd_ret) && !store_full_i;
    assign store_data_o  = hold_q ? hold_data_q : vfb_pkg::pixel_t'(rd_data_i);
    assign done_o        = done_q;

    always_comb begin
        cmd_o.write = 1'b0;
        cmd_o.addr  = base_i + vfb_pkg::mem_addr_t'(cnt_q);
        cmd_o.data  = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q        <= 1'b0;
            issued_all_q <= 1'b0;
            pending_q    <= 1'b0;
            hold_q       <= 1'b0;
            done_q       <= 1'b0;
            cnt_q        <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                run_q        <= 1'b1;
                issued_all_q <= 1'b0;
                cnt_q        <= '0;
            end else begin
                if (fire) begin
                    pending_q <= 1'b1;
                    cnt_q     <= cnt_q + 1'b1;
                    if (cnt_q == LAST) begin
                        issued_all_q <= 1'b1;
                    end
                end
                if (rd_ret) begin
                    pending_q <= 1'b0;
                    hold_q    <= store_full_i;
                end else if (hold_q && !store_full_i) begin
                    hold_q <= 1'b0;
                end
                // last word has left
                if (run_q && issued_all_q && !pending_q && !hold_q) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ret && store_full_i) begin
            hold_data_q <= vfb_pkg::pixel_t'(rd_data_i);
        end
    end

    // a refused word stays parked until the queue has room
    a_hold_full: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_ret || hold_q) && store_full_i) |=> hold_q)
        else $error("returned word dropped while the store queue was full");

    a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_valid_i |-> pending_q)
        else $error("read data returned with no read outstanding");

endmodule

/* source/frame_writer.sv */
`timescale 1ns/1ns
`include "vfb_macros.svh"

module frame_writer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  vfb_pkg::mem_addr_t base_i,
    input  logic               load_empty_i,
    input  vfb_pkg::pixel_t    load_data_i,
    output logic               load_rd_en_o,
    output vfb_pkg::mem_cmd_t  cmd_o,
    output logic               cmd_valid_o,
    input  logic               cmd_grant_i,
    output logic               done_o
);

    localparam int CNT_W = $clog2(`VFB_FRAME_PIXELS);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`VFB_FRAME_PIXELS - 1);

    logic             active_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    logic             fire;

    // stall while the load queue is empty
    assign cmd_valid_o  = active_q && !load_empty_i;
    assign fire         = cmd_valid_o && cmd_grant_i;
    assign load_rd_en_o = fire;
    assign done_o       = done_q;

    always_comb begin
        cmd_o.write = 1'b1;
        cmd_o.addr  = base_i + vfb_pkg::mem_addr_t'(cnt_q);
        cmd_o.data  = vfb_pkg::mem_data_t'(load_data_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            cnt_q    <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (fire) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == LAST) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/mem_cmd_arbiter.sv */
`timescale 1ns/1ns

module mem_cmd_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  vfb_pkg::mem_cmd_t  wr_cmd_i,
    input  vfb_pkg::mem_cmd_t  rd_cmd_i,
    input  logic               wr_valid_i,
    input  logic               rd_valid_i,
    output logic               wr_grant_o,
    output logic               rd_grant_o,
    output vfb_pkg::mem_addr_t addr_o,
    output logic               cmd_o,
    output logic               cmd_en_o,
    output vfb_pkg::mem_data_t wr_data_o
);

    logic              prio_rd;
    vfb_pkg::mem_cmd_t sel;

    assign wr_grant_o = wr_valid_i && (!rd_valid_i || !prio_rd);
    assign rd_grant_o = rd_valid_i && (!wr_valid_i || prio_rd);

    assign sel       = rd_grant_o ? rd_cmd_i : wr_cmd_i;
    assign cmd_en_o  = wr_grant_o || rd_grant_o;
    assign cmd_o     = cmd_en_o && sel.write;
    // idle port shows address zero
    assign addr_o    = cmd_en_o ? sel.addr : '0;
    assign wr_data_o = sel.data;

    // other side gets priority after each grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_rd <= 1'b0;
        end else if (cmd_en_o) begin
            prio_rd <= wr_grant_o;
        end
    end

    // a side that lost the last round wins the next one
    a_rr_to_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_grant_o && rd_valid_i) |=> (!rd_valid_i || rd_grant_o))
        else $error("reader skipped after losing to the writer");

    a_rr_to_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_grant_o && wr_valid_i) |=> (!wr_valid_i || wr_grant_o))
        else $error("writer skipped after losing to the reader");

    a_cmd_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_grant_o |-> wr_cmd_i.write) and (rd_grant_o |-> !rd_cmd_i.write))
        else $error("command type does not match the granted side");

endmodule

/* source/startup_timer.sv */
`timescale 1ns/1ns
`include "vfb_macros.svh"

module startup_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic init_done_i,
    output logic ready_o
);

    localparam int CNT_W = $clog2(`VFB_STARTUP_DELAY + 1);

    logic [CNT_W-1:0] cnt_q;

    // terminal count, held until reset
    assign ready_o = (cnt_q == CNT_W'(`VFB_STARTUP_DELAY));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (init_done_i && !ready_o) begin
            // gaps in init done just pause the count
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

/* source/vfb_macros.svh */
`ifndef VFB_MACROS_SVH
`define VFB_MACROS_SVH

// frame geometry in pixels
`define VFB_FRAME_W 8
`define VFB_FRAME_H 4
`define VFB_FRAME_PIXELS (`VFB_FRAME_W * `VFB_FRAME_H)

// triple buffering
`define VFB_NUM_BUFFERS 3

// spare words between two frames in memory
`define VFB_ADDR_GAP 16

// cycles of init done before the memory is usable
`define VFB_STARTUP_DELAY 20

`endif

/* source/vfb_pkg.sv */
package vfb_pkg;

    typedef logic [20:0] mem_addr_t;
    typedef logic [16:0] pixel_t;
    typedef logic [31:0] mem_data_t;
    typedef logic [1:0]  buf_idx_t;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITE_BUSY,
        BUF_READ_BUSY,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buf_state_e;

    typedef enum logic {
        ROLE_PRODUCER,
        ROLE_CONSUMER
    } seq_role_e;

    // sequencer to table
    typedef struct packed {
        logic acq;
        logic rel;
    } table_req_t;

    // table to sequencer, valid with grant
    typedef struct packed {
        logic      grant;
        buf_idx_t  idx;
        mem_addr_t base;
    } table_rsp_t;

    typedef struct packed {
        logic      write;
        mem_addr_t addr;
        mem_data_t data;
    } mem_cmd_t;

endpackage
